//--- Makefile
# Verilator build and run for the cache pair testbench
TOP := proc_mem_system_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
	  -f proc_mem_system.f -Mdir obj_dir -o sim

# Pass only when the log holds the pass line
run: compile
	./obj_dir/sim | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/proc_mem_system_tb.sv
//////////////////////////////
// Testbench for the cache pair; code in 0x0000-0x0FFF, data in 0x8000-0x8FFF
// Expects 16 lines of 4 words, index in address bits 5:2
//////////////////////////////
`timescale 1ns/10ps

module proc_mem_system_tb;
  import mem_pkg::*;

  localparam int MAX_CYCLES = 20000;  // ~300 accesses x 4 words x 4 waits, plus margin

  logic clk;
  logic arst_n;
  logic i_req;
  logic d_req;
  logic d_we;
  logic i_ready;
  logic d_ready;
  mem_addr_t i_addr;
  mem_addr_t d_addr;
  mem_word_t d_wdata;
  mem_word_t i_rdata;
  mem_word_t d_rdata;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic wb_ack;
  mem_addr_t wb_adr;
  mem_word_t wb_dat_w;
  mem_word_t wb_dat_r;

  mem_word_t   shadow [0:65535];      // Expected memory image
  logic [13:0] line_tag [2][16];      // Line address per cache and index with the icache at 0
  logic        line_vld [2][16];
  logic [31:0] log_adr [$];           // Acked transfers as {we, adr}
  mem_word_t   log_dat [$];
  int          cyc_cycles;
  int          n_checks;
  int          err_value;
  int          err_proto;

  proc_mem_system uut (.*);

  wb_mem_model u_mem (.clk(clk), .arst_n(arst_n), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we),
                      .adr(wb_adr), .dat_w(wb_dat_w), .dat_r(wb_dat_r), .ack(wb_ack));

  always #20 clk = ~clk;              // 40 ns period

  // Bus monitor
  always @(posedge clk) begin
    if (wb_cyc)
      cyc_cycles++;
    if (wb_cyc && wb_stb && wb_ack) begin
      log_adr.push_back({15'b0, wb_we, wb_adr});
      log_dat.push_back(wb_dat_w);
    end
  end

  //////////////////////////////
  // Protocol properties
  i_ready_idle: assert property (@(posedge clk) disable iff (!arst_n) !i_req |-> !i_ready)
    else proto_error("i_ready high without i_req");
  d_ready_idle: assert property (@(posedge clk) disable iff (!arst_n) !d_req |-> !d_ready)
    else proto_error("d_ready high without d_req");
  bus_idle: assert property (@(posedge clk) disable iff (!arst_n)
    (!i_req && !d_req) |-> (!wb_cyc && !wb_stb))
    else proto_error("bus active with no core request");
  stb_with_cyc: assert property (@(posedge clk) disable iff (!arst_n) wb_stb == wb_cyc)
    else proto_error("wb_stb and wb_cyc differ");
  bus_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (wb_cyc && !wb_ack) |=> (wb_cyc && wb_adr == $past(wb_adr) && wb_we == $past(wb_we)))
    else proto_error("bus cycle dropped or changed before ack");

  task automatic proto_error(input string what);
    err_proto++;
    $display("Protocol error at %0t: %s", $time, what);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    assert (act === exp)
    else begin
      err_value++;
      $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  // Known fill where every address bit matters
  function automatic mem_word_t pattern_word(input mem_addr_t a);
    return mem_word_t'(a * 16'h9e37) ^ {a[7:0], a[15:8]};
  endfunction

  // Bus words an access should cost; updates the line model
  function automatic int bus_words(input int c, input bit we, input mem_addr_t a);
    if (we)
      return 1;                       // Write-through without allocate
    if (line_vld[c][a[5:2]] && line_tag[c][a[5:2]] == a[15:2])
      return 0;
    line_vld[c][a[5:2]] = 1'b1;
    line_tag[c][a[5:2]] = a[15:2];
    return 4;
  endfunction

  // Core handshake started just after a falling edge
  task automatic core_access(input bit is_i, input bit we, input mem_addr_t a,
                             input mem_word_t wd, output mem_word_t rd, output int lat);
    if (is_i) begin
      i_req  = 1'b1;
      i_addr = a;
    end else begin
      d_req   = 1'b1;
      d_we    = we;
      d_addr  = a;
      d_wdata = wd;
    end
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (!(is_i ? i_ready : d_ready));
    rd = is_i ? i_rdata : d_rdata;
    @(negedge clk);
    if (is_i)
      i_req = 1'b0;
    else begin
      d_req = 1'b0;
      d_we  = 1'b0;
    end
  endtask

  task automatic run_op(input bit is_i, input bit we, input mem_addr_t a,
                        input mem_word_t wd, input string name);
    mem_word_t rd;
    int        lat;
    int        words;
    words = bus_words(is_i ? 0 : 1, we, a);
    log_adr.delete();
    log_dat.delete();
    cyc_cycles = 0;
    core_access(is_i, we, a, wd, rd, lat);
    check_value({name, " bus words"}, words, log_adr.size());
    if (we) begin
      shadow[a] = wd;
      if (log_adr.size() == 1) begin
        check_value({name, " wb adr"}, {15'b0, 1'b1, a}, log_adr[0]);
        check_value({name, " wb dat"}, 32'(wd), 32'(log_dat[0]));
      end
    end else begin
      check_value({name, " rdata"}, 32'(shadow[a]), 32'(rd));
      if (words == 0) begin
        check_value({name, " hit latency"}, 1, lat);      // Ready with req
        check_value({name, " wb_cyc cycles"}, 0, cyc_cycles);
      end
      for (int k = 0; k < 4 && k < log_adr.size(); k++)
        check_value({name, " fill adr"}, {15'b0, 1'b0, a[15:2], k[1:0]}, log_adr[k]);
    end
  endtask

  // Both caches miss in the same cycle
  task automatic dual_miss(input mem_addr_t ia, input mem_addr_t da);
    mem_word_t i_rd;
    mem_word_t d_rd;
    int        i_lat;
    int        d_lat;
    int        words;
    words = bus_words(0, 1'b0, ia) + bus_words(1, 1'b0, da);
    log_adr.delete();
    log_dat.delete();
    fork
      core_access(1'b1, 1'b0, ia, '0, i_rd, i_lat);
      core_access(1'b0, 1'b0, da, '0, d_rd, d_lat);
    join
    check_value("dual bus words", words, log_adr.size());
    check_value("dual first adr", {15'b0, 1'b0, ia[15:2], 2'b00}, log_adr[0]);
    check_value("dual i rdata", 32'(shadow[ia]), 32'(i_rd));
    check_value("dual d rdata", 32'(shadow[da]), 32'(d_rd));
  endtask

  //////////////////////////////
  // Main sequence
  initial begin
    logic [31:0] r;
    mem_addr_t   a;
    void'($urandom(32'h40d6_87ad));
    clk     = 1'b0;
    arst_n  = 1'b0;
    i_req   = 1'b0;
    i_addr  = '0;
    d_req   = 1'b0;
    d_we    = 1'b0;
    d_addr  = '0;
    d_wdata = '0;
    for (int i = 0; i < 65536; i++) begin
      shadow[i]    = pattern_word(mem_addr_t'(i));
      u_mem.mem[i] = shadow[i];
    end
    for (int i = 0; i < 32; i++)
      line_vld[i / 16][i % 16] = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    check_value("reset i_ready", 0, 32'(i_ready));
    check_value("reset d_ready", 0, 32'(d_ready));
    check_value("reset wb_cyc", 0, 32'(wb_cyc));
    check_value("reset wb_stb", 0, 32'(wb_stb));

    // Idle cycles out of reset with both requests low
    repeat (2) @(negedge clk);

    run_op(1'b1, 1'b0, 16'h0013, '0, "i_miss");
    for (int k = 0; k < 4; k++)
      run_op(1'b1, 1'b0, mem_addr_t'(16'h0010 + k), '0, "i_hit");
    run_op(1'b0, 1'b0, 16'h8005, '0, "d_miss");
    run_op(1'b0, 1'b0, 16'h8006, '0, "d_hit");
    run_op(1'b0, 1'b1, 16'h8041, 16'hbeef, "d_wr_miss");
    run_op(1'b0, 1'b0, 16'h8041, '0, "d_rd_after_wr_miss");  // Fills
    run_op(1'b0, 1'b1, 16'h8042, 16'h1234, "d_wr_hit");
    run_op(1'b0, 1'b0, 16'h8042, '0, "d_rd_after_wr_hit");
    dual_miss(16'h0200, 16'h8300);

    // Mixed traffic with a narrow window for hits and a wide one for misses
    for (int n = 0; n < 200; n++) begin
      r = $urandom;
      a = r[2] ? mem_addr_t'(r[27:16]) : mem_addr_t'(r[21:16]);
      case (r[1:0])
        2'd0:    run_op(1'b1, 1'b0, a, '0, "rand_i_rd");
        2'd1:    run_op(1'b0, 1'b0, a | 16'h8000, '0, "rand_d_rd");
        default: run_op(1'b0, 1'b1, a | 16'h8000, mem_word_t'($urandom), "rand_d_wr");
      endcase
    end

    $display("checks %0d, value errors %0d, protocol errors %0d", n_checks, err_value, err_proto);
    if (err_value == 0 && err_proto == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Run limit
  initial begin
    int cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("checks %0d, value errors %0d, protocol errors %0d", n_checks, err_value, err_proto);
    $display("sim failed");
    $finish;
  end

endmodule

//--- bench/wb_mem_model.sv
//////////////////////////////
// Wishbone classic slave memory, full 64K word space
// Registered ack after 0 to 3 random wait cycles, one word per cycle
//////////////////////////////
`timescale 1ns/10ps

module wb_mem_model (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                cyc,
  input  logic                stb,
  input  logic                we,
  input  mem_pkg::mem_addr_t  adr,
  input  mem_pkg::mem_word_t  dat_w,
  output mem_pkg::mem_word_t  dat_r,
  output logic                ack
);
  import mem_pkg::*;

  mem_word_t   mem [0:65535];   // Backdoor array, loaded by the testbench
  logic [1:0]  wait_q;          // Wait cycles left before ack
  logic [31:0] rnd;

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack    <= 1'b0;
      dat_r  <= '0;
      wait_q <= '0;
    end else if (ack) begin
      ack <= 1'b0;                  // Single-cycle ack
    end else if (cyc && stb) begin
      if (wait_q == 2'd0) begin
        ack   <= 1'b1;
        dat_r <= mem[adr];
        if (we)
          mem[adr] <= dat_w;
        rnd    = $urandom;
        wait_q <= rnd[1:0];         // Delay for the next transfer
      end else begin
        wait_q <= wait_q - 1'b1;
      end
    end
  end

endmodule

//--- proc_mem_system.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/mem_bus_if.sv
verilog/cache_ctrl.sv
verilog/mem_arbiter.sv
verilog/proc_mem_system.sv
bench/wb_mem_model.sv
bench/proc_mem_system_tb.sv

//--- verilog/cache_ctrl.sv
//////////////////////////////
// Direct-mapped cache, write-through, no allocate on write miss
// Read hit answers in the request cycle; a miss fills the whole line
// Core must hold req and fields until ready
//////////////////////////////
`timescale 1ns/10ps
`include "cache_macros.svh"

module cache_ctrl #(
  parameter bit WRITE_EN = 1'b1                 // 0 removes the write path
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                req,              // Access request from the core
  input  logic                we,               // Write when set
  input  mem_pkg::mem_addr_t  addr,             // Word address
  input  mem_pkg::mem_word_t  wdata,            // Store data
  output logic                ready,            // Access complete, one cycle
  output mem_pkg::mem_word_t  rdata,            // Load data, valid with ready
  mem_bus_if.master           bus               // Towards the arbiter
);
  import mem_pkg::*;

  ////////////////////////////
  // Address split and lookup
  ////////////////////////////
  cache_tag_t   tag;
  cache_index_t index;
  word_offset_t offset;

  assign {tag, index, offset} = addr;

  // Tag and data stores, valid bits kept apart
  cache_tag_t   tag_q  [`CACHE_LINES];
  mem_word_t    data_q [`CACHE_LINES][`CACHE_LINE_WORDS];
  logic [`CACHE_LINES-1:0] valid_q;

  cache_state_t state_q;
  logic         cyc_q;         // Registered cyc and stb
  word_offset_t fill_off_q;    // Next word of the line to fetch

  logic hit;
  logic wr_req;                // Write request, dead when WRITE_EN is 0
  logic wr_hit;                // Write to a cached word
  logic fill_ack;              // Fill word arrives this cycle
  logic line_done;             // Last word of the line arrives

  assign hit       = valid_q[index] && (tag_q[index] == tag);
  assign wr_req    = WRITE_EN && we;
  assign wr_hit    = (state_q == ST_IDLE) && req && wr_req && hit;
  assign fill_ack  = (state_q == ST_FILL) && cyc_q && bus.ack;
  assign line_done = fill_ack && (fill_off_q == word_offset_t'(`CACHE_LINE_WORDS - 1));

  ////////////////////////////
  // Core side
  ////////////////////////////
  // Read hits only in idle; a fill ends in idle so the hit follows next cycle
  assign ready = ((state_q == ST_IDLE) && req && !wr_req && hit) ||
                 ((state_q == ST_WRITE) && bus.ack);   // Write done with its ack
  assign rdata = data_q[index][offset];

  ////////////////////////////
  // Bus side
  ////////////////////////////
  assign bus.cyc   = cyc_q;
  assign bus.stb   = cyc_q;
  assign bus.we    = cyc_q && (state_q == ST_WRITE);
  assign bus.adr   = (state_q == ST_FILL) ? {tag, index, fill_off_q} : addr;  // Aligned line walk
  assign bus.dat_w = WRITE_EN ? wdata : '0;

  // Control FSM
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q    <= ST_IDLE;
      cyc_q      <= 1'b0;
      fill_off_q <= '0;
      valid_q    <= '0;        // Empty cache
    end else begin
      unique case (state_q)
        ST_IDLE: begin
          if (req && wr_req) begin
            state_q <= ST_WRITE;         // Every write goes out, hit or not
            cyc_q   <= 1'b1;
          end else if (req && !hit) begin
            state_q    <= ST_FILL;
            cyc_q      <= 1'b1;
            fill_off_q <= '0;            // Lowest word first
          end
        end
        ST_FILL: begin
          if (fill_ack) begin
            cyc_q      <= 1'b0;          // Drop cyc after each ack
            fill_off_q <= fill_off_q + 1'b1;
            if (line_done) begin
              valid_q[index] <= 1'b1;
              state_q        <= ST_IDLE;
            end
          end else if (!cyc_q) begin
            cyc_q <= 1'b1;               // Start the next word
          end
        end
        ST_WRITE: begin
          if (bus.ack) begin
            cyc_q   <= 1'b0;
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Store updates
  always_ff @(posedge clk) begin
    if (fill_ack)
      data_q[index][fill_off_q] <= bus.dat_r;   // Fill word from memory
    else if (wr_hit)
      data_q[index][offset] <= wdata;           // Keep cached copy current
    if (line_done)
      tag_q[index] <= tag;                      // Tag lands with the valid bit
  end

endmodule

//--- verilog/cache_macros.svh
//////////////////////////////
// Cache geometry shared by the package and the cache controller
// Addresses count 16-bit words, not bytes
// Line count and words per line must be powers of two
//////////////////////////////
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Word address width
`define CACHE_ADDR_W      16

// Data word width
`define CACHE_DATA_W      16

// Lines per cache, direct mapped
`define CACHE_LINES       16

// Words fetched per line fill
`define CACHE_LINE_WORDS  4

`endif

//--- verilog/mem_arbiter.sv
//////////////////////////////
// Fixed-priority Wishbone arbiter, instruction side wins ties
// Grant holds for the owner's whole bus cycle
//////////////////////////////
`timescale 1ns/10ps

module mem_arbiter (
  input  logic                clk,
  input  logic                arst_n,
  mem_bus_if.slave            icache_bus,   // Higher priority
  mem_bus_if.slave            dcache_bus,
  output logic                wb_cyc,
  output logic                wb_stb,
  output logic                wb_we,
  output mem_pkg::mem_addr_t  wb_adr,
  output mem_pkg::mem_word_t  wb_dat_w,
  input  mem_pkg::mem_word_t  wb_dat_r,
  input  logic                wb_ack
);

  logic owner_q;     // Last granted master, 1 = data cache
  logic owner_cyc;   // Owner still in its bus cycle
  logic sel_d;       // Current grant, 1 = data cache

  ////////////////////////////
  // Grant
  ////////////////////////////
  assign owner_cyc = owner_q ? dcache_bus.cyc : icache_bus.cyc;

  // Hold the owner mid cycle, else pick by priority in the same cycle
  assign sel_d = owner_cyc ? owner_q : (!icache_bus.cyc && dcache_bus.cyc);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      owner_q <= 1'b0;
    else
      owner_q <= sel_d;
  end

  ////////////////////////////
  // Steering
  ////////////////////////////
  assign wb_cyc   = sel_d ? dcache_bus.cyc   : icache_bus.cyc;
  assign wb_stb   = sel_d ? dcache_bus.stb   : icache_bus.stb;
  assign wb_we    = sel_d ? dcache_bus.we    : icache_bus.we;
  assign wb_adr   = sel_d ? dcache_bus.adr   : icache_bus.adr;
  assign wb_dat_w = sel_d ? dcache_bus.dat_w : icache_bus.dat_w;

  // Read data fans out, ack only to the winner
  assign icache_bus.dat_r = wb_dat_r;
  assign dcache_bus.dat_r = wb_dat_r;
  assign icache_bus.ack   = wb_ack && !sel_d;
  assign dcache_bus.ack   = wb_ack &&  sel_d;  // Loser waits with cyc held

endmodule

//--- verilog/mem_bus_if.sv
//////////////////////////////
// Wishbone classic link between one cache and the arbiter
// One word per bus cycle, no bursts
//////////////////////////////
`timescale 1ns/10ps

interface mem_bus_if;
  import mem_pkg::*;

  logic      cyc;    // Bus cycle in progress
  logic      stb;    // Transfer strobe, raised with cyc
  logic      we;     // 1 = write, 0 = read
  mem_addr_t adr;    // Word address
  mem_word_t dat_w;  // Write data from the master
  mem_word_t dat_r;  // Read data back to the master
  logic      ack;    // Transfer done, one cycle

  // Cache side
  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  // Arbiter side
  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

//--- verilog/mem_pkg.sv
//////////////////////////////
// Word, address and cache field types for the memory system
// Address splits as tag | index | offset, offset at the bottom
//////////////////////////////
`include "cache_macros.svh"

package mem_pkg;

  // Field widths derived from the geometry
  localparam int OFF_W = $clog2(`CACHE_LINE_WORDS);
  localparam int IDX_W = $clog2(`CACHE_LINES);
  localparam int TAG_W = `CACHE_ADDR_W - IDX_W - OFF_W;  // 10 bits with the default geometry

  typedef logic [`CACHE_DATA_W-1:0] mem_word_t;   // One data word
  typedef logic [`CACHE_ADDR_W-1:0] mem_addr_t;   // One word address
  typedef logic [TAG_W-1:0]         cache_tag_t;  // Upper address bits
  typedef logic [IDX_W-1:0]         cache_index_t;
  typedef logic [OFF_W-1:0]         word_offset_t;

  // Cache controller states
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,  // Serves hits, waits for a request
    ST_FILL  = 2'd1,  // Fetches a line word by word
    ST_WRITE = 2'd2   // One write-through bus cycle
  } cache_state_t;

endpackage

//--- verilog/proc_mem_system.sv
//////////////////////////////
// Instruction and data caches sharing one Wishbone master port
// Caches are not coherent; keep code and data apart
//////////////////////////////
`timescale 1ns/10ps

module proc_mem_system (
  input  logic                clk,
  input  logic                arst_n,

  // Instruction side, read only
  input  logic                i_req,
  input  mem_pkg::mem_addr_t  i_addr,
  output logic                i_ready,
  output mem_pkg::mem_word_t  i_rdata,

  // Data side
  input  logic                d_req,
  input  logic                d_we,
  input  mem_pkg::mem_addr_t  d_addr,
  input  mem_pkg::mem_word_t  d_wdata,
  output logic                d_ready,
  output mem_pkg::mem_word_t  d_rdata,

  // External Wishbone master
  output logic                wb_cyc,
  output logic                wb_stb,
  output logic                wb_we,
  output mem_pkg::mem_addr_t  wb_adr,
  output mem_pkg::mem_word_t  wb_dat_w,
  input  mem_pkg::mem_word_t  wb_dat_r,
  input  logic                wb_ack
);
  import mem_pkg::*;

  localparam mem_word_t NO_WDATA = '0;   // Instruction cache never stores

  mem_bus_if icache_bus ();
  mem_bus_if dcache_bus ();

  ////////////////////////////
  // Caches
  ////////////////////////////
  cache_ctrl #(.WRITE_EN(1'b0)) u_icache (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (i_req),
    .we     (1'b0),
    .addr   (i_addr),
    .wdata  (NO_WDATA),
    .ready  (i_ready),
    .rdata  (i_rdata),
    .bus    (icache_bus.master)
  );

  cache_ctrl #(.WRITE_EN(1'b1)) u_dcache (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (d_req),
    .we     (d_we),
    .addr   (d_addr),
    .wdata  (d_wdata),
    .ready  (d_ready),
    .rdata  (d_rdata),
    .bus    (dcache_bus.master)
  );

  ////////////////////////////
  // Shared bus
  ////////////////////////////
  mem_arbiter u_arb (
    .clk        (clk),
    .arst_n     (arst_n),
    .icache_bus (icache_bus.slave),
    .dcache_bus (dcache_bus.slave),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack)
  );

endmodule
